// ==== Makefile ====
# Verilator flow for the gb io glue

TOP       ?= tb_gb_io
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -Wno-fatal --timescale $(TIMESCALE) \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/bus_decoder.sv ====
/*
 * bus decoder
 * turns the cpu address into one-hot selects, holds the select and the
 * acknowledge for a cycle and then returns the matching byte
 */
`default_nettype none

module bus_decoder (
	input  logic             clk_cpu,
	input  logic             reset,
	input  gb_pkg::cpu_bus_t bus,
	input  logic             irq_ack,
	input  logic             gbc_mode,
	output gb_pkg::io_sel_t  sel,
	input  gb_pkg::byte_t    joy_do,
	input  gb_pkg::byte_t    sb_do,
	input  gb_pkg::byte_t    sc_do,
	input  gb_pkg::byte_t    if_do,
	input  gb_pkg::byte_t    ie_do,
	input  gb_pkg::byte_t    vec_do,
	input  gb_pkg::byte_t    svbk_do,
	input  gb_pkg::byte_t    wram_do,
	input  gb_pkg::byte_t    hram_do,
	output gb_pkg::byte_t    rdata,
	output logic             rd_valid
);
	import gb_pkg::*;

	io_sel_t sel_q;   // select of the read in flight
	logic    ack_q;   // ack in flight, vector wins

	// -------------------- address decode
	always_comb begin
		sel       = '0;
		sel.joy   = (bus.addr == JOYP_ADDR);
		sel.sb    = (bus.addr == SB_ADDR);
		sel.sc    = (bus.addr == SC_ADDR);
		sel.iflag = (bus.addr == IF_ADDR);
		sel.ie    = (bus.addr == IE_ADDR);
		sel.svbk  = gbc_mode && (bus.addr == SVBK_ADDR);  // colour mode only
		// c000-fdff, e000 up echoes c000
		sel.wram  = (bus.addr >= WRAM_BASE) && (bus.addr <= WRAM_END);
		// ff80-fffe, ffff is IE
		sel.hram  = (bus.addr >= HRAM_BASE) && (bus.addr != IE_ADDR);
	end

	// -------------------- read pipeline
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sel_q    <= '0;
			ack_q    <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			sel_q    <= bus.rd ? sel : '0;  // only reads matter here
			ack_q    <= irq_ack;
			rd_valid <= bus.rd | irq_ack;
		end
	end

	// mux on the held select, rams have their q by now
	always_comb begin
		if (ack_q)
			rdata = vec_do;        // interrupt vector
		else if (sel_q.joy)
			rdata = joy_do;
		else if (sel_q.sb)
			rdata = sb_do;
		else if (sel_q.sc)
			rdata = sc_do;
		else if (sel_q.iflag)
			rdata = if_do;
		else if (sel_q.ie)
			rdata = ie_do;
		else if (sel_q.svbk)
			rdata = svbk_do;
		else if (sel_q.wram)
			rdata = wram_do;
		else if (sel_q.hram)
			rdata = hram_do;
		else
			rdata = OPEN_BUS;      // unmapped
	end

endmodule

`default_nettype wire

// ==== design/gb_io_top.sv ====
/*
 * gb io top
 * memory mapped system glue: address decode, interrupt controller,
 * joypad, serial port, work ram and high ram behind one cpu bus
 */
`default_nettype none

module gb_io_top (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_pkg::cpu_bus_t    bus,
	input  logic                irq_ack,
	input  gb_pkg::irq_events_t events,
	input  logic                gbc_mode,
	input  gb_pkg::keys_t       joy_din,
	output gb_pkg::byte_t       rdata,
	output logic                rd_valid,
	output logic                irq_n,
	output logic [1:0]          joy_p54,
	output logic                sc_int_clock
);
	import gb_pkg::*;

	io_sel_t sel;

	// unregistered read bytes, ram data comes one cycle late
	byte_t joy_do;
	byte_t sb_do;
	byte_t sc_do;
	byte_t if_do;
	byte_t ie_do;
	byte_t vec_do;
	byte_t svbk_do;
	byte_t wram_do;
	byte_t hram_do;

	logic serial_irq;  // one cycle pulses into IF
	logic joy_irq;

	// -------------------- decode and read back
	bus_decoder u_dec (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.bus      (bus),
		.irq_ack  (irq_ack),
		.gbc_mode (gbc_mode),
		.sel      (sel),
		.joy_do   (joy_do),
		.sb_do    (sb_do),
		.sc_do    (sc_do),
		.if_do    (if_do),
		.ie_do    (ie_do),
		.vec_do   (vec_do),
		.svbk_do  (svbk_do),
		.wram_do  (wram_do),
		.hram_do  (hram_do),
		.rdata    (rdata),
		.rd_valid (rd_valid)
	);

	// -------------------- peripherals
	interrupt_ctrl u_irq (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus),
		.sel_if     (sel.iflag),
		.sel_ie     (sel.ie),
		.irq_ack    (irq_ack),
		.events     (events),
		.serial_irq (serial_irq),
		.joy_irq    (joy_irq),
		.if_do      (if_do),
		.ie_do      (ie_do),
		.vec_do     (vec_do),
		.irq_n      (irq_n)
	);

	serial_port u_serial (
		.clk_cpu      (clk_cpu),
		.reset        (reset),
		.bus          (bus),
		.sel_sb       (sel.sb),
		.sel_sc       (sel.sc),
		.sb_do        (sb_do),
		.sc_do        (sc_do),
		.serial_irq   (serial_irq),
		.sc_int_clock (sc_int_clock)
	);

	joypad u_joy (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.bus     (bus),
		.sel_joy (sel.joy),
		.joy_din (joy_din),
		.joy_do  (joy_do),
		.joy_p54 (joy_p54),
		.joy_irq (joy_irq)
	);

	// -------------------- rams
	work_ram u_ram (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.bus      (bus),
		.sel_wram (sel.wram),
		.sel_hram (sel.hram),
		.sel_svbk (sel.svbk),
		.wram_do  (wram_do),
		.hram_do  (hram_do),
		.svbk_do  (svbk_do)
	);

endmodule

`default_nettype wire

// ==== design/gb_pkg.sv ====
/*
 * gb io package
 * shared widths, bus and select structs, address map and interrupt
 * constants for the handheld console system glue
 */
`default_nettype none

package gb_pkg;

	// -------------------- widths
	localparam int ADDR_W        = 16;
	localparam int DATA_W        = 8;
	localparam int IRQ_W         = 5;   // vblank, lcd, timer, serial, joypad
	localparam int KEY_W         = 4;   // P10..P13
	localparam int WRAM_ADDR_W   = 15;  // 32k, eight 4k banks
	localparam int HRAM_ADDR_W   = 7;   // 128 entries, ff80-fffe used
	localparam int WRAM_BANK_W   = 3;
	localparam int WRAM_WIN_W    = WRAM_ADDR_W - WRAM_BANK_W;  // 4k window
	localparam int SERIAL_DIV_W  = 9;
	localparam int SERIAL_BITS   = 8;
	localparam int SERIAL_CNT_W  = $clog2(SERIAL_BITS + 1);
	localparam int SERIAL_CYCLES = 4097;  // start write to irq

	// -------------------- types
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [IRQ_W-1:0] irq_vec_t;           // bit 0 vblank .. bit 4 joypad
	typedef logic [$clog2(IRQ_W)-1:0] irq_idx_t;
	typedef logic [KEY_W-1:0] keys_t;
	typedef logic [WRAM_BANK_W-1:0] wram_bank_t;

	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  wr;     // one cycle strobe
		logic  rd;     // one cycle strobe
	} cpu_bus_t;

	// one-hot, at most one bit per address
	typedef struct packed {
		logic joy;
		logic sb;
		logic sc;
		logic iflag;   // IF at ff0f
		logic ie;
		logic svbk;
		logic wram;
		logic hram;
	} io_sel_t;

	typedef struct packed {
		logic vblank;
		logic lcd;
		logic timer;
	} irq_events_t;

	// -------------------- address map
	localparam addr_t JOYP_ADDR = 16'hFF00;
	localparam addr_t SB_ADDR   = 16'hFF01;
	localparam addr_t SC_ADDR   = 16'hFF02;
	localparam addr_t IF_ADDR   = 16'hFF0F;
	localparam addr_t SVBK_ADDR = 16'hFF70;
	localparam addr_t HRAM_BASE = 16'hFF80;
	localparam addr_t IE_ADDR   = 16'hFFFF;
	localparam addr_t WRAM_BASE = 16'hC000;
	localparam addr_t WRAM_END  = 16'hFDFF;  // includes echo area

	// -------------------- interrupts
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	localparam byte_t IRQ_VEC_BASE = 8'h40;
	localparam byte_t IRQ_VEC_STEP = 8'h08;
	localparam byte_t IRQ_VEC_NONE = 8'h55;  // nothing pending on ack

	localparam byte_t OPEN_BUS = 8'hFF;

	// divider reload so that 8 bit periods plus the irq cycle give SERIAL_CYCLES
	localparam logic [SERIAL_DIV_W-1:0] SERIAL_DIV_LAST =
		SERIAL_DIV_W'((SERIAL_CYCLES - 1) / SERIAL_BITS - 1);

endpackage

`default_nettype wire

// ==== design/interrupt_ctrl.sv ====
/*
 * interrupt controller
 * IE and IF registers, rising edge capture of the external events,
 * priority acknowledge with vector latch, active low irq to the cpu
 */
`default_nettype none

module interrupt_ctrl (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_pkg::cpu_bus_t    bus,
	input  logic                sel_if,
	input  logic                sel_ie,
	input  logic                irq_ack,
	input  gb_pkg::irq_events_t events,
	input  logic                serial_irq,
	input  logic                joy_irq,
	output gb_pkg::byte_t       if_do,
	output gb_pkg::byte_t       ie_do,
	output gb_pkg::byte_t       vec_do,
	output logic                irq_n
);
	import gb_pkg::*;

	irq_vec_t    if_r;
	irq_vec_t    ie_r;
	irq_vec_t    pending;   // flagged and enabled
	irq_vec_t    raised;    // new requests this cycle
	irq_vec_t    ack_clr;
	irq_events_t ev_d;
	irq_events_t ev_dd;
	irq_events_t ev_rise;
	irq_idx_t    pend_idx;
	logic        pend_any;
	byte_t       vec_next;

	assign pending = if_r & ie_r;
	assign irq_n   = ~|pending;
	assign if_do   = {3'b111, if_r};
	assign ie_do   = {3'b000, ie_r};
	assign ev_rise = ev_d & ~ev_dd;  // low to high on a registered copy

	// -------------------- priority
	// lowest index wins, so scan down and keep the last hit
	always_comb begin
		pend_idx = '0;
		pend_any = 1'b0;
		for (int i = IRQ_W - 1; i >= 0; i--) begin
			if (pending[i]) begin
				pend_idx = irq_idx_t'(i);
				pend_any = 1'b1;
			end
		end
	end

	assign vec_next = pend_any ? IRQ_VEC_BASE + IRQ_VEC_STEP * byte_t'(pend_idx) : IRQ_VEC_NONE;
	assign ack_clr  = pend_any ? (irq_vec_t'(1) << pend_idx) : '0;

	always_comb begin
		raised             = '0;
		raised[IRQ_VBLANK] = ev_rise.vblank;
		raised[IRQ_LCD]    = ev_rise.lcd;
		raised[IRQ_TIMER]  = ev_rise.timer;
		raised[IRQ_SERIAL] = serial_irq;  // already a pulse
		raised[IRQ_JOYPAD] = joy_irq;
	end

	// -------------------- registers
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			ev_d  <= '0;
			ev_dd <= '0;
		end else begin
			ev_d  <= events;
			ev_dd <= ev_d;
			if (bus.wr && sel_if)
				if_r <= bus.wdata[IRQ_W-1:0];       // cpu write replaces all
			else if (irq_ack)
				if_r <= (if_r & ~ack_clr) | raised;  // new event beats the clear
			else
				if_r <= if_r | raised;
			if (bus.wr && sel_ie)
				ie_r <= bus.wdata[IRQ_W-1:0];
		end
	end

	// vector held for the read back cycle
	always_ff @(posedge clk_cpu) begin
		if (irq_ack)
			vec_do <= vec_next;
	end

endmodule

`default_nettype wire

// ==== design/joypad.sv ====
/*
 * joypad
 * P1 line select register, key read back and falling edge
 * interrupt request through a two stage synchronizer
 */
`default_nettype none

module joypad (
	input  logic             clk_cpu,
	input  logic             reset,
	input  gb_pkg::cpu_bus_t bus,
	input  logic             sel_joy,
	input  gb_pkg::keys_t    joy_din,
	output gb_pkg::byte_t    joy_do,
	output logic [1:0]       joy_p54,
	output logic             joy_irq
);
	import gb_pkg::*;

	keys_t key_s1;   // sync stages, keys idle high
	keys_t key_s2;
	keys_t key_old;

	assign joy_do = {2'b11, joy_p54, joy_din};

	always_ff @(posedge clk_cpu) begin
		if (reset)
			joy_p54 <= 2'b11;  // nothing selected
		else if (bus.wr && sel_joy)
			joy_p54 <= bus.wdata[5:4];
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			key_s1  <= '1;
			key_s2  <= '1;
			key_old <= '1;
			joy_irq <= 1'b0;
		end else begin
			key_s1  <= joy_din;
			key_s2  <= key_s1;
			key_old <= key_s2;
			joy_irq <= |(key_old & ~key_s2);  // any line 1 -> 0
		end
	end

endmodule

`default_nettype wire

// ==== design/serial_port.sv ====
/*
 * serial port, no link partner
 * SB and SC registers, internally clocked transfer timed by a divider
 * and bit counter, interrupt pulse at the end of the transfer
 */
`default_nettype none

module serial_port (
	input  logic             clk_cpu,
	input  logic             reset,
	input  gb_pkg::cpu_bus_t bus,
	input  logic             sel_sb,
	input  logic             sel_sc,
	output gb_pkg::byte_t    sb_do,
	output gb_pkg::byte_t    sc_do,
	output logic             serial_irq,
	output logic             sc_int_clock
);
	import gb_pkg::*;

	byte_t                   sb_q;
	logic                    sc_start;   // SC bit 7
	logic                    sc_clk_int; // SC bit 0
	logic [SERIAL_DIV_W-1:0] div_q;
	logic [SERIAL_CNT_W-1:0] bit_cnt;    // bits still to go
	logic                    running;
	logic                    bit_tick;

	assign running      = sc_start & sc_clk_int;  // external clock never arrives
	assign bit_tick     = running && (div_q == '0) && (bit_cnt != '0);
	assign sc_do        = {sc_start, 6'h3F, sc_clk_int};
	assign sb_do        = sb_q;
	assign sc_int_clock = sc_clk_int;

	// -------------------- SC and timing
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start   <= 1'b0;
			sc_clk_int <= 1'b0;
			div_q      <= SERIAL_DIV_LAST;
			bit_cnt    <= '0;
			serial_irq <= 1'b0;
		end else begin
			serial_irq <= 1'b0;
			if (bus.wr && sel_sc) begin
				sc_start   <= bus.wdata[7];
				sc_clk_int <= bus.wdata[0];
				div_q      <= SERIAL_DIV_LAST;  // restart the bit period
				bit_cnt    <= SERIAL_CNT_W'(SERIAL_BITS);
			end else if (running) begin
				div_q <= div_q - 1'b1;
				if (bit_tick) begin
					bit_cnt    <= bit_cnt - 1'b1;
					serial_irq <= (bit_cnt == SERIAL_CNT_W'(1));  // last bit out
				end
				if (serial_irq)
					sc_start <= 1'b0;  // done, same edge as IF
			end
		end
	end

	// SB shifts in the idle high line, ends as ff after a transfer
	always_ff @(posedge clk_cpu) begin
		if (reset)
			sb_q <= OPEN_BUS;
		else if (bus.wr && sel_sb)
			sb_q <= bus.wdata;
		else if (bit_tick)
			sb_q <= {sb_q[DATA_W-2:0], 1'b1};
	end

endmodule

`default_nettype wire

// ==== design/spram.sv ====
/*
 * single port ram
 * byte wide, synchronous write and registered read
 */
`default_nettype none

module spram #(
	parameter int ADDR_W = 8
) (
	input  logic              clk_cpu,
	input  logic [ADDR_W-1:0] address,
	input  logic              wren,
	input  gb_pkg::byte_t     data,
	output gb_pkg::byte_t     q
);
	import gb_pkg::*;

	byte_t mem [2**ADDR_W];

	always_ff @(posedge clk_cpu) begin
		if (wren)
			mem[address] <= data;
		q <= mem[address];  // old data on a write cycle
	end

endmodule

`default_nettype wire

// ==== design/work_ram.sv ====
/*
 * work ram and high ram
 * 32k banked work ram with the SVBK bank register, upper 4k window
 * follows the bank, plus 127 bytes of high ram
 */
`default_nettype none

module work_ram (
	input  logic             clk_cpu,
	input  logic             reset,
	input  gb_pkg::cpu_bus_t bus,
	input  logic             sel_wram,
	input  logic             sel_hram,
	input  logic             sel_svbk,
	output gb_pkg::byte_t    wram_do,
	output gb_pkg::byte_t    hram_do,
	output gb_pkg::byte_t    svbk_do
);
	import gb_pkg::*;

	wram_bank_t             bank;   // 1..7
	logic [WRAM_ADDR_W-1:0] wram_addr;

	// d000 window (and its echo) maps through the bank, c000 is bank 0
	assign wram_addr = bus.addr[WRAM_WIN_W] ? {bank, bus.addr[WRAM_WIN_W-1:0]}
	                                        : {WRAM_BANK_W'(0), bus.addr[WRAM_WIN_W-1:0]};
	assign svbk_do   = {5'h1F, bank};

	// -------------------- SVBK
	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank <= WRAM_BANK_W'(1);
		else if (bus.wr && sel_svbk)
			bank <= (bus.wdata[WRAM_BANK_W-1:0] == '0) ? WRAM_BANK_W'(1)  // 0 acts as 1
			                                          : bus.wdata[WRAM_BANK_W-1:0];
	end

	// -------------------- arrays
	spram #(.ADDR_W(WRAM_ADDR_W)) u_wram (
		.clk_cpu (clk_cpu),
		.address (wram_addr),
		.wren    (bus.wr & sel_wram),
		.data    (bus.wdata),
		.q       (wram_do)
	);

	spram #(.ADDR_W(HRAM_ADDR_W)) u_hram (
		.clk_cpu (clk_cpu),
		.address (bus.addr[HRAM_ADDR_W-1:0]),  // ff80 up, entry 7f never selected
		.wren    (bus.wr & sel_hram),
		.data    (bus.wdata),
		.q       (hram_do)
	);

endmodule

`default_nettype wire

// ==== project.f ====
design/gb_pkg.sv
design/spram.sv
design/work_ram.sv
design/joypad.sv
design/serial_port.sv
design/interrupt_ctrl.sv
design/bus_decoder.sv
design/gb_io_top.sv
testbench/tb_gb_io.sv

// ==== testbench/gb_io_golden.mem ====
// columns: op addr data expect, op 1 write, 2 read, 3 ack, 4 event {vblank,lcd,timer},
// 5 wait addr cycles, 6 gbc_mode, 7 joy_din, 8 irq_n check, 0 end
08 0000 00 01  // reset values
02 ffff 00 00
02 ff0f 00 e0
02 ff00 00 ff
02 ff02 00 7e
02 ff01 00 ff
02 ff10 00 ff  // unmapped
01 ff00 20 00  // select p15 low
02 ff00 00 ef
06 0000 01 00  // colour mode
01 ff70 02 00
01 d123 a2 00
01 ff70 05 00
01 d123 a5 00
02 d123 00 a5
02 ff70 00 fd
01 ff70 02 00
02 d123 00 a2
01 ff70 00 00  // bank 0 acts as 1
02 ff70 00 f9
01 c123 3c 00
02 e123 00 3c  // echo
06 0000 00 00
02 ff70 00 ff
01 ff80 11 00  // high ram
01 fffe ee 00
02 ff80 00 11
02 fffe 00 ee
01 ffff 1f 00
02 ffff 00 1f
04 0000 01 00  // timer then vblank
04 0000 04 00
05 0002 00 00
02 ff0f 00 e5
08 0000 00 00
03 0000 00 40
03 0000 00 50
03 0000 00 55
08 0000 00 01
07 0000 0b 00  // key line 2 down
05 0004 00 00
02 ff0f 00 f0
02 ff00 00 eb
03 0000 00 60
07 0000 0f 00
01 ff02 81 00  // serial start, internal clock
02 ff02 00 ff
05 1068 00 00
02 ff02 00 7f
02 ff0f 00 e8
02 ff01 00 ff
03 0000 00 58
08 0000 00 01
00 0000 00 00

// ==== testbench/tb_gb_io.sv ====
/*
 * testbench for the gb io glue
 * replays bus operations from a golden file against the top level,
 * compares every read back and vector with the expected byte
 */
`default_nettype none

module tb_gb_io;
	timeunit 1ns;
	timeprecision 100ps;

	import gb_pkg::*;

	localparam int MAX_OPS   = 128;
	localparam int RESET_CYC = 16;

	// op codes, first column of the golden file
	localparam byte_t OP_END   = 8'h00;
	localparam byte_t OP_WRITE = 8'h01;
	localparam byte_t OP_READ  = 8'h02;
	localparam byte_t OP_ACK   = 8'h03;
	localparam byte_t OP_EVENT = 8'h04;
	localparam byte_t OP_WAIT  = 8'h05;
	localparam byte_t OP_MODE  = 8'h06;
	localparam byte_t OP_KEYS  = 8'h07;
	localparam byte_t OP_IRQ   = 8'h08;
	localparam byte_t OP_P54   = 8'h09;
	localparam byte_t OP_SCCLK = 8'h0A;

	logic        clk_cpu;
	logic        reset;
	cpu_bus_t    bus;
	logic        irq_ack;
	irq_events_t events;
	logic        gbc_mode;
	keys_t       joy_din;
	byte_t       rdata;
	logic        rd_valid;
	logic        irq_n;
	logic [1:0]  joy_p54;
	logic        sc_int_clock;

	logic [15:0] golden [0:4*MAX_OPS-1];  // four words per op
	int          errors;
	int          checks;
	int          budget;      // watchdog limit in cycles
	logic        budget_set;

	gb_io_top dut0 (
		.clk_cpu      (clk_cpu),
		.reset        (reset),
		.bus          (bus),
		.irq_ack      (irq_ack),
		.events       (events),
		.gbc_mode     (gbc_mode),
		.joy_din      (joy_din),
		.rdata        (rdata),
		.rd_valid     (rd_valid),
		.irq_n        (irq_n),
		.joy_p54      (joy_p54),
		.sc_int_clock (sc_int_clock)
	);

	// 100 ns period
	initial begin
		clk_cpu = 1'b0;
		forever #50ns clk_cpu = ~clk_cpu;
	end

	// -------------------- bus tasks
	task automatic next_cycle();
		@(posedge clk_cpu);
		#10ns;  // drive point, outputs settled
	endtask

	task automatic write_byte(input addr_t addr, input byte_t data);
		bus.addr  = addr;
		bus.wdata = data;
		bus.wr    = 1'b1;
		next_cycle();
		bus.wr    = 1'b0;
		checks++;
		if (rd_valid !== 1'b0) begin  // no read data for a write
			$display("[FAIL] rd_valid after write to %h: got %h, expected 0", addr, rd_valid);
			errors++;
		end
	endtask

	task automatic read_check(input addr_t addr, input byte_t exp_val);
		bus.addr = addr;
		bus.rd   = 1'b1;
		next_cycle();
		bus.rd   = 1'b0;
		checks++;
		if (rd_valid !== 1'b1) begin  // exactly one cycle after the strobe
			$display("[FAIL] rd_valid after read of %h: got %h, expected 1", addr, rd_valid);
			errors++;
		end else if (rdata !== exp_val) begin
			$display("[FAIL] rdata at %h: got %h, expected %h", addr, rdata, exp_val);
			errors++;
		end
	endtask

	task automatic ack_check(input byte_t exp_val);
		irq_ack = 1'b1;
		next_cycle();
		irq_ack = 1'b0;
		checks++;
		if (rd_valid !== 1'b1) begin
			$display("[FAIL] rd_valid after acknowledge: got %h, expected 1", rd_valid);
			errors++;
		end else if (rdata !== exp_val) begin
			$display("[FAIL] rdata vector: got %h, expected %h", rdata, exp_val);
			errors++;
		end
	endtask

	task automatic pulse_events(input irq_events_t ev);
		events = ev;  // one cycle wide
		next_cycle();
		events = '0;
	endtask

	task automatic irq_check(input logic exp_val);
		checks++;
		if (irq_n !== exp_val) begin
			$display("[FAIL] irq_n: got %h, expected %h", irq_n, exp_val);
			errors++;
		end
	endtask

	task automatic p54_check(input logic [1:0] exp_val);
		checks++;
		if (joy_p54 !== exp_val) begin
			$display("[FAIL] joy_p54: got %h, expected %h", joy_p54, exp_val);
			errors++;
		end
	endtask

	task automatic clock_sel_check(input logic exp_val);
		checks++;
		if (sc_int_clock !== exp_val) begin
			$display("[FAIL] sc_int_clock: got %h, expected %h", sc_int_clock, exp_val);
			errors++;
		end
	endtask

	// nominal length of one golden entry, never below the real one
	function automatic int op_cycles(input byte_t op, input addr_t arg);
		case (op)
			OP_READ, OP_ACK: return 2;
			OP_WAIT:         return int'(arg);
			default:         return 1;
		endcase
	endfunction

	// -------------------- main sequence
	initial begin
		int    n_ops;
		int    total;
		byte_t op;
		addr_t arg;
		byte_t data;
		byte_t exp_val;

		reset      = 1'b1;
		bus        = '0;
		irq_ack    = 1'b0;
		events     = '0;
		gbc_mode   = 1'b0;
		joy_din    = 4'hF;  // keys released
		errors     = 0;
		checks     = 0;
		budget     = 0;
		budget_set = 1'b0;

		$readmemh("testbench/gb_io_golden.mem", golden);

		// count entries up to the end marker
		n_ops = 0;
		total = RESET_CYC;
		while (n_ops < MAX_OPS && !$isunknown(golden[4*n_ops])
		       && golden[4*n_ops] != 16'(OP_END)) begin
			total += op_cycles(byte_t'(golden[4*n_ops]), golden[4*n_ops+1]);
			n_ops++;
		end
		budget     = total + total / 10;  // ten percent margin
		budget_set = 1'b1;
		if (n_ops == 0) begin
			$display("golden file holds no operations");
			errors++;
		end

		repeat (RESET_CYC) next_cycle();
		reset = 1'b0;

		for (int i = 0; i < n_ops; i++) begin
			op      = byte_t'(golden[4*i]);
			arg     = golden[4*i+1];
			data    = byte_t'(golden[4*i+2]);
			exp_val = byte_t'(golden[4*i+3]);
			case (op)
				OP_WRITE: write_byte(arg, data);
				OP_READ:  read_check(arg, exp_val);
				OP_ACK:   ack_check(exp_val);
				OP_EVENT: pulse_events(irq_events_t'(data[2:0]));
				OP_WAIT:  repeat (arg) next_cycle();
				OP_MODE: begin
					gbc_mode = data[0];
					next_cycle();
				end
				OP_KEYS: begin
					joy_din = keys_t'(data[3:0]);
					next_cycle();
				end
				OP_IRQ:   irq_check(exp_val[0]);
				OP_P54:   p54_check(exp_val[1:0]);
				OP_SCCLK: clock_sel_check(exp_val[0]);
				default: begin
					$display("unknown op %h in golden entry %0d", op, i);
					errors++;
				end
			endcase
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// -------------------- watchdog
	initial begin
		wait (budget_set);
		repeat (budget) @(posedge clk_cpu);
		$display("run did not end within %0d cycles, checks: %0d, errors: %0d",
		         budget, checks, errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
